// ==== vlog.f ====
src/dcache_cfg_pkg.sv
src/dcache_types_pkg.sv
src/core_req_arbiter.sv
src/stride_prefetcher.sv
src/dcache_ctrl.sv
src/dcache_front.sv
tests/tb_dcache_front.sv

// ==== Makefile ====
TOP       ?= tb_dcache_front
SEED_LOG  ?= sim.log
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f vlog.f
	./$(OBJ_DIR)/V$(TOP) > $(SEED_LOG) 2>&1; status=$$?; \
	cat $(SEED_LOG); \
	if grep -q "Simulation finished: FAIL" $(SEED_LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(SEED_LOG)

// ==== tests/tb_dcache_front.sv ====
// ################################################
// Testbench for the data cache front end
// Table-driven core traffic against a memory model
// ################################################

`timescale 1ns/1ps
`default_nettype none

module tb_dcache_front;

  localparam logic [31:0]  RDATA_KEY    = 32'h5a5a_0000;
  localparam logic [31:0]  SEED         = 32'h6ec6;
  localparam int unsigned  NUM_ROWS     = 11;
  localparam int unsigned  ACK_TIMEOUT  = 100;
  localparam int unsigned  MEM_TIMEOUT  = 100;
  localparam int unsigned  LOG_TIMEOUT  = 60;
  localparam int unsigned  QUIET_CYCLES = 12;
  localparam dcache_types_pkg::mem_op_e OP_RD = dcache_types_pkg::READ;
  localparam dcache_types_pkg::mem_op_e OP_WR = dcache_types_pkg::WRITE;
  localparam dcache_types_pkg::mem_op_e OP_PF = dcache_types_pkg::PREFETCH;

  // One stimulus row with its expected memory traffic
  typedef struct packed {
    logic [dcache_cfg_pkg::SRC_W-1:0]  port;
    dcache_types_pkg::mem_op_e         op;
    logic [dcache_cfg_pkg::ADDR_W-1:0] addr;
    logic [dcache_cfg_pkg::DATA_W-1:0] wdata;
    logic                              pf_en;
    dcache_types_pkg::mem_op_e         exp_op;
    logic                              exp_pf;
  } row_t;

  logic                                                 clk_i;
  logic                                                 rst_ni;
  logic                                                 pf_enable_i;
  logic [dcache_cfg_pkg::NUM_PORTS-1:0]                 core_req_i;
  dcache_types_pkg::core_req_t [dcache_cfg_pkg::NUM_PORTS-1:0] core_req_data_i;
  logic [dcache_cfg_pkg::NUM_PORTS-1:0]                 core_ack_o;
  logic [dcache_cfg_pkg::NUM_PORTS-1:0][dcache_cfg_pkg::DATA_W-1:0] core_rdata_o;
  logic                                                 mem_req_o;
  dcache_types_pkg::mem_req_t                           mem_req_data_o;
  logic                                                 mem_ack_i;
  logic [dcache_cfg_pkg::DATA_W-1:0]                    mem_rdata_i;
  logic                                                 flush_req_i;
  logic                                                 flush_ack_o;
  logic [dcache_cfg_pkg::PF_CNT_W-1:0]                  pf_count_o;

  row_t                                rows [NUM_ROWS];
  dcache_types_pkg::mem_req_t          mem_log [$];
  logic [dcache_cfg_pkg::PF_CNT_W-1:0] exp_count;

  dcache_front dcache_front_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .pf_enable_i     (pf_enable_i),
    .core_req_i      (core_req_i),
    .core_req_data_i (core_req_data_i),
    .core_ack_o      (core_ack_o),
    .core_rdata_o    (core_rdata_o),
    .mem_req_o       (mem_req_o),
    .mem_req_data_o  (mem_req_data_o),
    .mem_ack_i       (mem_ack_i),
    .mem_rdata_i     (mem_rdata_i),
    .flush_req_i     (flush_req_i),
    .flush_ack_o     (flush_ack_o),
    .pf_count_o      (pf_count_o)
  );

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_mem_req(input string name, input dcache_types_pkg::mem_req_t exp,
                               input dcache_types_pkg::mem_req_t act);
    if (act !== exp) begin
      fail_now({$sformatf("** Error at %0t: %s expected op=%0d addr=%h wdata=%h src=%0d",
                          $time, name, exp.op, exp.addr, exp.wdata, exp.src),
                $sformatf(", got op=%0d addr=%h wdata=%h src=%0d",
                          act.op, act.addr, act.wdata, act.src)});
    end
  endtask

  task automatic check_rdata(input string name, input logic [dcache_cfg_pkg::DATA_W-1:0] exp,
                             input logic [dcache_cfg_pkg::DATA_W-1:0] act);
    if (act !== exp) begin
      fail_now($sformatf("** Error at %0t: %s expected %h, got %h", $time, name, exp, act));
    end
  endtask

  task automatic check_count(input string name, input logic [dcache_cfg_pkg::PF_CNT_W-1:0] exp,
                             input logic [dcache_cfg_pkg::PF_CNT_W-1:0] act);
    if (act !== exp) begin
      fail_now($sformatf("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      fail_now($sformatf("** Error at %0t: %s expected %b, got %b", $time, name, exp, act));
    end
  endtask

  task automatic check_acks(input string name, input logic [dcache_cfg_pkg::NUM_PORTS-1:0] exp,
                            input logic [dcache_cfg_pkg::NUM_PORTS-1:0] act);
    if (act !== exp) begin
      fail_now($sformatf("** Error at %0t: %s expected %b, got %b", $time, name, exp, act));
    end
  endtask

  function automatic dcache_types_pkg::mem_req_t make_mem_req(
    input dcache_types_pkg::mem_op_e         op,
    input logic [dcache_cfg_pkg::ADDR_W-1:0] addr,
    input logic [dcache_cfg_pkg::DATA_W-1:0] wdata,
    input logic [dcache_cfg_pkg::SRC_W-1:0]  src
  );
    dcache_types_pkg::mem_req_t r;
    r.op    = op;
    r.addr  = addr;
    r.wdata = wdata;
    r.src   = src;
    return r;
  endfunction

  task automatic set_row(input int idx, input logic [1:0] port,
                         input dcache_types_pkg::mem_op_e op, input logic [31:0] addr,
                         input logic [31:0] wdata, input logic pf_en,
                         input dcache_types_pkg::mem_op_e exp_op, input logic exp_pf);
    rows[idx] = '{port, op, addr, wdata, pf_en, exp_op, exp_pf};
  endtask

  task automatic fill_table();
    set_row(0,  2'd0, OP_RD, 32'h1000_0040, 32'h0000_0000, 1'b0, OP_RD, 1'b0);
    set_row(1,  2'd1, OP_RD, 32'h2000_0100, 32'h0000_0000, 1'b0, OP_RD, 1'b0);
    set_row(2,  2'd2, OP_WR, 32'h3000_0008, 32'hdead_beef, 1'b0, OP_WR, 1'b0);
    // Stride of 0x40 with the prefetcher on
    set_row(3,  2'd0, OP_RD, 32'h0000_4000, 32'h0000_0000, 1'b1, OP_RD, 1'b0);
    set_row(4,  2'd1, OP_RD, 32'h0000_4040, 32'h0000_0000, 1'b1, OP_RD, 1'b0);
    set_row(5,  2'd0, OP_RD, 32'h0000_4080, 32'h0000_0000, 1'b1, OP_RD, 1'b1);
    // Same pattern with the prefetcher off
    set_row(6,  2'd1, OP_RD, 32'h0000_8000, 32'h0000_0000, 1'b0, OP_RD, 1'b0);
    set_row(7,  2'd0, OP_RD, 32'h0000_8100, 32'h0000_0000, 1'b0, OP_RD, 1'b0);
    set_row(8,  2'd1, OP_RD, 32'h0000_8200, 32'h0000_0000, 1'b0, OP_RD, 1'b0);
    // After the flush, would hit on a stale history
    set_row(9,  2'd0, OP_RD, 32'h0000_c000, 32'h0000_0000, 1'b1, OP_RD, 1'b0);
    set_row(10, 2'd1, OP_RD, 32'h0000_c020, 32'h0000_0000, 1'b1, OP_RD, 1'b0);
  endtask

  // Memory model with random ack delay
  initial begin : mem_model
    int unsigned delay;
    int unsigned guard;
    void'($urandom(SEED));
    forever begin
      @(posedge clk_i);
      if (rst_ni && mem_req_o && !mem_ack_i) begin
        mem_log.push_back(mem_req_data_o);
        delay = $urandom_range(3, 0);
        repeat (delay) @(posedge clk_i);
        mem_ack_i   <= 1'b1;
        mem_rdata_i <= mem_req_data_o.addr ^ RDATA_KEY;
        guard = 0;
        do begin
          @(posedge clk_i);
          guard++;
          if (guard > MEM_TIMEOUT) fail_now("Timeout waiting for mem_req_o to fall");
        end while (mem_req_o);
        mem_ack_i <= 1'b0;
      end
    end
  end

  // Full four-phase handshake on one core port
  task automatic run_port(input int unsigned k, input dcache_types_pkg::core_req_t req);
    int unsigned guard;
    @(posedge clk_i);
    core_req_data_i[k] <= req;
    core_req_i[k]      <= 1'b1;
    guard = 0;
    do begin
      @(posedge clk_i);
      guard++;
      if (guard > ACK_TIMEOUT) fail_now($sformatf("Timeout waiting for core_ack_o[%0d]", k));
    end while (!core_ack_o[k]);
    if (req.op == OP_RD) begin
      check_rdata($sformatf("core_rdata_o[%0d]", k), req.addr ^ RDATA_KEY, core_rdata_o[k]);
    end
    core_req_i[k] <= 1'b0;
    guard = 0;
    do begin
      @(posedge clk_i);
      guard++;
      if (guard > ACK_TIMEOUT) fail_now($sformatf("core_ack_o[%0d] did not fall", k));
    end while (core_ack_o[k]);
  endtask

  task automatic expect_mem_req(input dcache_types_pkg::mem_req_t exp);
    dcache_types_pkg::mem_req_t got;
    int unsigned guard;
    guard = 0;
    while (mem_log.size() == 0) begin
      @(posedge clk_i);
      guard++;
      if (guard > LOG_TIMEOUT) fail_now("Timeout waiting for a memory request");
    end
    got = mem_log.pop_front();
    check_mem_req("mem_req_data_o", exp, got);
  endtask

  task automatic apply_row(input int idx);
    row_t                        r;
    dcache_types_pkg::core_req_t req;
    logic [31:0]                 prev_addr;
    r         = rows[idx];
    prev_addr = (idx > 0) ? rows[idx-1].addr : 32'h0;
    req.op    = r.op;
    req.addr  = r.addr;
    req.wdata = r.wdata;
    @(posedge clk_i);
    pf_enable_i <= r.pf_en;
    run_port(r.port, req);
    expect_mem_req(make_mem_req(r.exp_op, r.addr, r.wdata, r.port));
    if (r.exp_pf) begin
      // Next address along the stride of the last two rows
      expect_mem_req(make_mem_req(OP_PF, r.addr + (r.addr - prev_addr), '0,
                                  dcache_cfg_pkg::PF_SRC));
      exp_count = exp_count + 1'b1;
    end else begin
      repeat (QUIET_CYCLES) @(posedge clk_i);
      if (mem_log.size() != 0) fail_now($sformatf("Unexpected memory request after row %0d", idx));
    end
    check_count("pf_count_o", exp_count, pf_count_o);
  endtask

  // Flush raised while the store still holds the memory port
  task automatic do_flush();
    int unsigned guard;
    guard = 0;
    do begin
      @(posedge clk_i);
      guard++;
      if (guard > MEM_TIMEOUT) fail_now("Timeout waiting for the store on the memory port");
    end while (!(mem_req_o && mem_req_data_o.src == 2'd2));
    flush_req_i <= 1'b1;
    guard = 0;
    do begin
      @(posedge clk_i);
      guard++;
      if (guard > ACK_TIMEOUT) fail_now("Timeout waiting for flush_ack_o to rise");
    end while (!flush_ack_o);
    // Ack only once the memory handshake is over
    check_flag("mem_req_o", 1'b0, mem_req_o);
    check_flag("mem_ack_i", 1'b0, mem_ack_i);
    flush_req_i <= 1'b0;
    guard = 0;
    do begin
      @(posedge clk_i);
      guard++;
      if (guard > ACK_TIMEOUT) fail_now("Timeout waiting for flush_ack_o to fall");
    end while (flush_ack_o);
  endtask

  initial begin : stimulus
    dcache_types_pkg::core_req_t req0;
    dcache_types_pkg::core_req_t req1;
    dcache_types_pkg::core_req_t req2;
    rst_ni          = 1'b0;
    pf_enable_i     = 1'b0;
    core_req_i      = '0;
    core_req_data_i = '0;
    mem_ack_i       = 1'b0;
    mem_rdata_i     = '0;
    flush_req_i     = 1'b0;
    exp_count       = '0;
    fill_table();
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    check_flag("mem_req_o", 1'b0, mem_req_o);
    check_acks("core_ack_o", '0, core_ack_o);
    check_flag("flush_ack_o", 1'b0, flush_ack_o);
    check_count("pf_count_o", '0, pf_count_o);

    for (int i = 0; i < 9; i++) begin
      apply_row(i);
    end

    // Three ports raised together, served lowest port first
    req0 = '{OP_RD, 32'h0000_9000, 32'h0};
    req1 = '{OP_RD, 32'h0000_bfc0, 32'h0};
    req2 = '{OP_WR, 32'h0000_bfe0, 32'h1234_5678};
    // The flush has to wait for the store in flight
    fork
      run_port(2, req2);
      run_port(1, req1);
      run_port(0, req0);
      do_flush();
    join
    expect_mem_req(make_mem_req(OP_RD, req0.addr, req0.wdata, 2'd0));
    expect_mem_req(make_mem_req(OP_RD, req1.addr, req1.wdata, 2'd1));
    expect_mem_req(make_mem_req(OP_WR, req2.addr, req2.wdata, 2'd2));

    apply_row(9);
    apply_row(10);
    check_count("pf_count_o", exp_count, pf_count_o);

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule : tb_dcache_front

`default_nettype wire

// ==== src/dcache_front.sv ====
// ################################################
// L1 data cache front end
// Arbiter, stride prefetcher and controller
// ################################################

`timescale 1ns/1ps
`default_nettype none

module dcache_front (
  input  logic                                                    clk_i,
  input  logic                                                    rst_ni,
  input  logic                                                    pf_enable_i,
  input  logic [dcache_cfg_pkg::NUM_PORTS-1:0]                    core_req_i,
  input  dcache_types_pkg::core_req_t [dcache_cfg_pkg::NUM_PORTS-1:0] core_req_data_i,
  output logic [dcache_cfg_pkg::NUM_PORTS-1:0]                    core_ack_o,
  output logic [dcache_cfg_pkg::NUM_PORTS-1:0][dcache_cfg_pkg::DATA_W-1:0] core_rdata_o,
  output logic                                                    mem_req_o,
  output dcache_types_pkg::mem_req_t                              mem_req_data_o,
  input  logic                                                    mem_ack_i,
  input  logic [dcache_cfg_pkg::DATA_W-1:0]                       mem_rdata_i,
  input  logic                                                    flush_req_i,
  output logic                                                    flush_ack_o,
  output logic [dcache_cfg_pkg::PF_CNT_W-1:0]                     pf_count_o
);

  logic                              grant_valid;
  dcache_types_pkg::mem_req_t        grant_req;
  logic                              pf_valid;
  logic [dcache_cfg_pkg::ADDR_W-1:0] pf_addr;
  dcache_types_pkg::snoop_t          snoop;
  logic                              pf_issued;
  logic                              flush_clear;

  core_req_arbiter i_core_req_arbiter (
    .core_req_i      (core_req_i),
    .core_req_data_i (core_req_data_i),
    .core_ack_i      (core_ack_o),
    .pf_valid_i      (pf_valid),
    .pf_addr_i       (pf_addr),
    .grant_valid_o   (grant_valid),
    .grant_req_o     (grant_req)
  );

  stride_prefetcher i_stride_prefetcher (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .pf_enable_i (pf_enable_i),
    .snoop_i     (snoop),
    .pf_issued_i (pf_issued),
    .flush_i     (flush_clear),
    .pf_valid_o  (pf_valid),
    .pf_addr_o   (pf_addr),
    .pf_count_o  (pf_count_o)
  );

  dcache_ctrl i_dcache_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .grant_valid_i  (grant_valid),
    .grant_req_i    (grant_req),
    .core_req_i     (core_req_i),
    .flush_req_i    (flush_req_i),
    .mem_ack_i      (mem_ack_i),
    .mem_rdata_i    (mem_rdata_i),
    .mem_req_o      (mem_req_o),
    .mem_req_data_o (mem_req_data_o),
    .core_ack_o     (core_ack_o),
    .core_rdata_o   (core_rdata_o),
    .snoop_o        (snoop),
    .pf_issued_o    (pf_issued),
    .flush_clear_o  (flush_clear),
    .flush_ack_o    (flush_ack_o)
  );

endmodule : dcache_front

`default_nettype wire

// ==== src/dcache_ctrl.sv ====
// ################################################
// Front end controller
// Runs the memory handshake, returns core acks,
// issues prefetches and serves flush requests
// ################################################

`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
  input  logic                                                    clk_i,
  input  logic                                                    rst_ni,
  input  logic                                                    grant_valid_i,
  input  dcache_types_pkg::mem_req_t                              grant_req_i,
  input  logic [dcache_cfg_pkg::NUM_PORTS-1:0]                    core_req_i,
  input  logic                                                    flush_req_i,
  input  logic                                                    mem_ack_i,
  input  logic [dcache_cfg_pkg::DATA_W-1:0]                       mem_rdata_i,
  output logic                                                    mem_req_o,
  output dcache_types_pkg::mem_req_t                              mem_req_data_o,
  output logic [dcache_cfg_pkg::NUM_PORTS-1:0]                    core_ack_o,
  output logic [dcache_cfg_pkg::NUM_PORTS-1:0][dcache_cfg_pkg::DATA_W-1:0] core_rdata_o,
  output dcache_types_pkg::snoop_t                                snoop_o,
  output logic                                                    pf_issued_o,
  output logic                                                    flush_clear_o,
  output logic                                                    flush_ack_o
);

  dcache_types_pkg::ctrl_state_e state_q, state_d;
  dcache_types_pkg::mem_req_t    req_q;
  logic [dcache_cfg_pkg::NUM_PORTS-1:0]                           ack_q;
  logic [dcache_cfg_pkg::NUM_PORTS-1:0][dcache_cfg_pkg::DATA_W-1:0] rdata_q;
  logic accept;
  logic core_done;

  // Flush wins over a grant in the same cycle
  assign accept    = (state_q == dcache_types_pkg::IDLE) && !flush_req_i && grant_valid_i;
  assign core_done = (state_q == dcache_types_pkg::MEM_REQ) && mem_ack_i
                  && (req_q.src != dcache_cfg_pkg::PF_SRC);

  always_comb begin
    state_d = state_q;
    case (state_q)
      dcache_types_pkg::IDLE: begin
        if (flush_req_i) state_d = dcache_types_pkg::FLUSH_ACK;
        else if (grant_valid_i) state_d = dcache_types_pkg::MEM_REQ;
      end
      dcache_types_pkg::MEM_REQ: begin
        if (mem_ack_i) state_d = dcache_types_pkg::MEM_RELEASE;
      end
      // Memory must drop its ack before the next request
      dcache_types_pkg::MEM_RELEASE: begin
        if (!mem_ack_i) state_d = dcache_types_pkg::IDLE;
      end
      dcache_types_pkg::FLUSH_ACK: begin
        if (!flush_req_i) state_d = dcache_types_pkg::IDLE;
      end
      default: state_d = dcache_types_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) state_q <= dcache_types_pkg::IDLE;
    else state_q <= state_d;
  end

  always_ff @(posedge clk_i) begin
    if (accept) req_q <= grant_req_i;
  end

  // Per-port ack, held until that port drops its req
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= '0;
    end else begin
      for (int k = 0; k < dcache_cfg_pkg::NUM_PORTS; k++) begin
        if (ack_q[k] && !core_req_i[k]) ack_q[k] <= 1'b0;
        if (core_done && req_q.src == dcache_cfg_pkg::SRC_W'(k)) ack_q[k] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int k = 0; k < dcache_cfg_pkg::NUM_PORTS; k++) begin
      if (core_done && req_q.src == dcache_cfg_pkg::SRC_W'(k)) rdata_q[k] <= mem_rdata_i;
    end
  end

  assign mem_req_o      = (state_q == dcache_types_pkg::MEM_REQ);
  assign mem_req_data_o = req_q;
  assign core_ack_o     = ack_q;
  assign core_rdata_o   = rdata_q;
  assign flush_ack_o    = (state_q == dcache_types_pkg::FLUSH_ACK);
  assign flush_clear_o  = (state_q == dcache_types_pkg::IDLE) && flush_req_i;

  // Strobes toward the prefetcher at accept
  assign snoop_o.valid = accept && (grant_req_i.src != dcache_cfg_pkg::PF_SRC);
  assign snoop_o.addr  = grant_req_i.addr;
  assign pf_issued_o   = accept && (grant_req_i.src == dcache_cfg_pkg::PF_SRC);

  // A new memory request starts only after memory has dropped its ack
  a_mem_req_after_release: assert property (
    @(posedge clk_i) disable iff (!rst_ni) $rose(mem_req_o) |-> !$past(mem_ack_i)
  ) else $error("mem_req_o raised while mem_ack_i was still high");

  for (genvar k = 0; k < dcache_cfg_pkg::NUM_PORTS; k++) begin : gen_ack_chk
    a_ack_needs_req: assert property (
      @(posedge clk_i) disable iff (!rst_ni) $rose(ack_q[k]) |-> $past(core_req_i[k])
    ) else $error("core ack rose on port %0d without a request", k);
  end

endmodule : dcache_ctrl

`default_nettype wire

// ==== src/stride_prefetcher.sv ====
// ################################################
// Stride prefetcher
// Snoops accepted accesses and proposes the next
// address after two equal non-zero strides
// ################################################

`timescale 1ns/1ps
`default_nettype none

module stride_prefetcher (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  pf_enable_i,
  input  dcache_types_pkg::snoop_t              snoop_i,
  input  logic                                  pf_issued_i,
  input  logic                                  flush_i,
  output logic                                  pf_valid_o,
  output logic [dcache_cfg_pkg::ADDR_W-1:0]     pf_addr_o,
  output logic [dcache_cfg_pkg::PF_CNT_W-1:0]   pf_count_o
);

  logic [dcache_cfg_pkg::ADDR_W-1:0]   last_addr_q;
  logic [dcache_cfg_pkg::ADDR_W-1:0]   last_stride_q;
  logic [dcache_cfg_pkg::ADDR_W-1:0]   new_stride;
  // Number of valid history entries, saturates at 2
  logic [1:0]                          depth_q;
  logic                                stride_hit;
  logic                                pf_valid_q;
  logic [dcache_cfg_pkg::ADDR_W-1:0]   pf_addr_q;
  logic [dcache_cfg_pkg::PF_CNT_W-1:0] pf_count_q;

  assign new_stride = snoop_i.addr - last_addr_q;

  // Needs a full history, a repeated stride and a non-zero step
  assign stride_hit = snoop_i.valid && (depth_q == 2'd2) && pf_enable_i
                   && (new_stride == last_stride_q) && (new_stride != '0);

  // Stride history
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_addr_q   <= '0;
      last_stride_q <= '0;
      depth_q       <= 2'd0;
    end else if (flush_i) begin
      depth_q <= 2'd0;
    end else if (snoop_i.valid) begin
      last_addr_q <= snoop_i.addr;
      if (depth_q != 2'd0) begin
        last_stride_q <= new_stride;
      end
      if (depth_q != 2'd2) begin
        depth_q <= depth_q + 2'd1;
      end
    end
  end

  // Candidate valid, a newer hit replaces an older candidate
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pf_valid_q <= 1'b0;
    end else if (flush_i) begin
      pf_valid_q <= 1'b0;
    end else if (stride_hit) begin
      pf_valid_q <= 1'b1;
    end else if (pf_issued_i) begin
      pf_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (stride_hit) begin
      pf_addr_q <= snoop_i.addr + new_stride;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pf_count_q <= '0;
    end else if (pf_issued_i) begin
      pf_count_q <= pf_count_q + 1'b1;
    end
  end

  assign pf_valid_o = pf_valid_q;
  assign pf_addr_o  = pf_addr_q;
  assign pf_count_o = pf_count_q;

  // The controller only issues a candidate that is on offer
  a_issue_needs_candidate: assert property (
    @(posedge clk_i) disable iff (!rst_ni) pf_issued_i |-> pf_valid_q
  ) else $error("prefetch issued without a valid candidate");

endmodule : stride_prefetcher

`default_nettype wire

// ==== src/core_req_arbiter.sv ====
// ################################################
// Core request arbiter
// Fixed priority over core ports, prefetch last
// ################################################

`timescale 1ns/1ps
`default_nettype none

module core_req_arbiter (
  input  logic [dcache_cfg_pkg::NUM_PORTS-1:0]                  core_req_i,
  input  dcache_types_pkg::core_req_t [dcache_cfg_pkg::NUM_PORTS-1:0] core_req_data_i,
  input  logic [dcache_cfg_pkg::NUM_PORTS-1:0]                  core_ack_i,
  input  logic                                                  pf_valid_i,
  input  logic [dcache_cfg_pkg::ADDR_W-1:0]                     pf_addr_i,
  output logic                                                  grant_valid_o,
  output dcache_types_pkg::mem_req_t                            grant_req_o
);

  logic [dcache_cfg_pkg::NUM_PORTS-1:0] pending;
  // One bit per source, prefetcher in the top bit
  logic [dcache_cfg_pkg::NUM_PORTS:0]   sel;
  // Port bit of the granted source, zero for the prefetcher
  logic [dcache_cfg_pkg::NUM_PORTS-1:0] win_bit;

  // A port with its ack still high is finishing its handshake
  assign pending = core_req_i & ~core_ack_i;

  always_comb begin
    logic found;
    found       = 1'b0;
    sel         = '0;
    grant_req_o = '0;
    for (int k = 0; k < dcache_cfg_pkg::NUM_PORTS; k++) begin
      if (pending[k] && !found) begin
        found             = 1'b1;
        sel[k]            = 1'b1;
        grant_req_o.op    = core_req_data_i[k].op;
        grant_req_o.addr  = core_req_data_i[k].addr;
        grant_req_o.wdata = core_req_data_i[k].wdata;
        grant_req_o.src   = dcache_cfg_pkg::SRC_W'(k);
      end
    end
    // Prefetch only fills otherwise idle slots
    if (!found && pf_valid_i) begin
      sel[dcache_cfg_pkg::NUM_PORTS] = 1'b1;
      grant_req_o.op                 = dcache_types_pkg::PREFETCH;
      grant_req_o.addr               = pf_addr_i;
      grant_req_o.wdata              = '0;
      grant_req_o.src                = dcache_cfg_pkg::PF_SRC;
    end
  end

  assign grant_valid_o = |sel;

  assign win_bit = dcache_cfg_pkg::NUM_PORTS'(1) << grant_req_o.src;

  // Granted source is the only one that may win, no pending port below it
  a_single_source: assert final (
    !grant_valid_o
    || (((pending & (win_bit - 1'b1)) == '0)
        && ((grant_req_o.src == dcache_cfg_pkg::PF_SRC) ? pf_valid_i
                                                         : ((pending & win_bit) != '0)))
  ) else $error("arbiter grant to source %0d skips a pending port: %b",
                grant_req_o.src, pending);

endmodule : core_req_arbiter

`default_nettype wire

// ==== src/dcache_types_pkg.sv ====
// ################################################
// Data cache front end types
// Request structs, operation and FSM state enums
// ################################################

`default_nettype none

package dcache_types_pkg;

  // Operation carried on the memory port
  typedef enum logic [1:0] {
    READ     = 2'd0,
    WRITE    = 2'd1,
    PREFETCH = 2'd2
  } mem_op_e;

  // One request as presented by a core port
  typedef struct packed {
    mem_op_e                             op;
    logic [dcache_cfg_pkg::ADDR_W-1:0]   addr;
    logic [dcache_cfg_pkg::DATA_W-1:0]   wdata;
  } core_req_t;

  // Request toward memory, tagged with its source
  typedef struct packed {
    mem_op_e                             op;
    logic [dcache_cfg_pkg::ADDR_W-1:0]   addr;
    logic [dcache_cfg_pkg::DATA_W-1:0]   wdata;
    logic [dcache_cfg_pkg::SRC_W-1:0]    src;
  } mem_req_t;

  // Controller FSM
  typedef enum logic [1:0] {
    IDLE        = 2'd0,
    MEM_REQ     = 2'd1,
    MEM_RELEASE = 2'd2,
    FLUSH_ACK   = 2'd3
  } ctrl_state_e;

  // Accepted core access seen by the prefetcher
  typedef struct packed {
    logic                                valid;
    logic [dcache_cfg_pkg::ADDR_W-1:0]   addr;
  } snoop_t;

endpackage : dcache_types_pkg

`default_nettype wire

// ==== src/dcache_cfg_pkg.sv ====
// ################################################
// Data cache front end configuration
// Sizes, port counts and reserved source ids
// ################################################

`default_nettype none

package dcache_cfg_pkg;

  // Address and data word widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // Core ports, loads first and the store port last
  localparam int unsigned NUM_LOAD_PORTS = 2;
  localparam int unsigned NUM_PORTS      = NUM_LOAD_PORTS + 1;

  // Source ids cover every core port plus the prefetcher
  localparam int unsigned SRC_W = 2;
  localparam logic [SRC_W-1:0] PF_SRC = SRC_W'(NUM_PORTS);

  // Issued prefetch counter
  localparam int unsigned PF_CNT_W = 16;

endpackage : dcache_cfg_pkg

`default_nettype wire
